//--- logic/cdb_if.sv
interface cdb_if;
    import isa_pkg::*;

    logic alu_valid;
    preg_t alu_tag;
    word_t alu_data;
    logic mul_valid;
    preg_t mul_tag;
    word_t mul_data;
    logic div_valid;
    preg_t div_tag;
    word_t div_data;

    // tag match over the live buses, alu first, then mul, then div
    function automatic logic lookup(input preg_t tag, output word_t value);
        logic found;
        found = 1'b1;
        value = '0;
        if (alu_valid && alu_tag == tag) begin
            value = alu_data;
        end else if (mul_valid && mul_tag == tag) begin
            value = mul_data;
        end else if (div_valid && div_tag == tag) begin
            value = div_data;
        end else begin
            found = 1'b0;
        end
        return found;
    endfunction

    modport source (
        output alu_valid, alu_tag, alu_data,
        output mul_valid, mul_tag, mul_data,
        output div_valid, div_tag, div_data
    );

    modport sink (
        input alu_valid, alu_tag, alu_data,
        input mul_valid, mul_tag, mul_data,
        input div_valid, div_tag, div_data,
        import lookup
    );

endinterface

//--- logic/isa_pkg.sv
`include "rs_params.svh"

package isa_pkg;

    // machine level words seen by every functional unit
    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`TAG_W-1:0] preg_t; // physical register
    typedef logic [`PC_W-1:0] pc_t;
    typedef logic [`OP_W-1:0] div_op_t;

endpackage

//--- logic/rs_alloc_if.sv
interface rs_alloc_if;
    import rs_pkg::*;

    logic write;          // only when dispatching and not full
    rs_idx_t idx;         // lowest free entry
    rs_payload_t payload;
    operand_u src1;
    operand_u src2;
    logic src1_ready;
    logic src2_ready;

    modport ctrl (
        output write, idx
    );

    modport capture (
        output payload, src1, src2, src1_ready, src2_ready
    );

    modport store (
        input write, idx,
        input payload, src1, src2, src1_ready, src2_ready
    );

endinterface

//--- logic/rs_div.sv
module rs_div (
    input logic clk,
    input logic reset,
    input logic dispatch_valid,
    input isa_pkg::pc_t dispatch_pc,
    input isa_pkg::preg_t dispatch_rd,
    input isa_pkg::div_op_t dispatch_op,
    input logic src1_ready,
    input isa_pkg::word_t src1_word,  // tag in low bits when not ready
    input logic src2_ready,
    input isa_pkg::word_t src2_word,
    input logic alu_valid,
    input isa_pkg::preg_t alu_tag,
    input isa_pkg::word_t alu_data,
    input logic mul_valid,
    input isa_pkg::preg_t mul_tag,
    input isa_pkg::word_t mul_data,
    input logic div_valid,
    input isa_pkg::preg_t div_tag,
    input isa_pkg::word_t div_data,
    output logic issue_valid,
    output isa_pkg::pc_t issue_pc,
    output isa_pkg::preg_t issue_rd,
    output isa_pkg::div_op_t issue_op,
    output isa_pkg::word_t issue_src1,
    output isa_pkg::word_t issue_src2,
    output logic rs_full
);
    import rs_pkg::*;

    cdb_if cdb ();
    rs_alloc_if alloc ();

    rs_vec_t entry_ready;
    logic issue_fire;
    rs_idx_t issue_idx;
    rs_idx_t read_idx;
    issue_word_t read_word;

    assign cdb.alu_valid = alu_valid;
    assign cdb.alu_tag = alu_tag;
    assign cdb.alu_data = alu_data;
    assign cdb.mul_valid = mul_valid;
    assign cdb.mul_tag = mul_tag;
    assign cdb.mul_data = mul_data;
    assign cdb.div_valid = div_valid;
    assign cdb.div_tag = div_tag;
    assign cdb.div_data = div_data;

    rs_operand_capture rs_operand_capture_i (
        .dispatch_pc(dispatch_pc),
        .dispatch_rd(dispatch_rd),
        .dispatch_op(dispatch_op),
        .src1_ready(src1_ready),
        .src1_word(operand_u'(src1_word)),
        .src2_ready(src2_ready),
        .src2_word(operand_u'(src2_word)),
        .cdb(cdb.sink),
        .alloc(alloc.capture)
    );

    rs_entry_store rs_entry_store_i (
        .clk(clk),
        .reset(reset),
        .cdb(cdb.sink),
        .alloc(alloc.store),
        .read_idx(read_idx),
        .read_word(read_word),
        .entry_ready(entry_ready)
    );

    rs_div_ctrl rs_div_ctrl_i (
        .clk(clk),
        .reset(reset),
        .dispatch_valid(dispatch_valid),
        .entry_ready(entry_ready),
        .alloc(alloc.ctrl),
        .issue_fire(issue_fire),
        .issue_idx(issue_idx),
        .rs_full(rs_full)
    );

    rs_issue_mux rs_issue_mux_i (
        .clk(clk),
        .reset(reset),
        .issue_fire(issue_fire),
        .issue_idx(issue_idx),
        .read_idx(read_idx),
        .read_word(read_word),
        .issue_valid(issue_valid),
        .issue_pc(issue_pc),
        .issue_rd(issue_rd),
        .issue_op(issue_op),
        .issue_src1(issue_src1),
        .issue_src2(issue_src2)
    );

endmodule

//--- logic/rs_div_ctrl.sv
`include "rs_params.svh"

module rs_div_ctrl (
    input logic clk,
    input logic reset,
    input logic dispatch_valid,
    input rs_pkg::rs_vec_t entry_ready,
    rs_alloc_if.ctrl alloc,
    output logic issue_fire,
    output rs_pkg::rs_idx_t issue_idx,
    output logic rs_full
);
    import rs_pkg::*;

    rs_vec_t valid_q;    // occupied entries
    rs_vec_t issuable;
    rs_idx_t free_idx;
    logic do_alloc;

    assign issuable = valid_q & entry_ready;
    assign rs_full = &valid_q;
    assign issue_fire = |issuable;
    assign do_alloc = dispatch_valid && !rs_full; // lost when full

    // walk down so the lowest index wins
    always_comb begin
        free_idx = '0;
        issue_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) free_idx = rs_idx_t'(i);
            if (issuable[i]) issue_idx = rs_idx_t'(i);
        end
    end

    assign alloc.write = do_alloc;
    assign alloc.idx = free_idx;

    // alloc picks a free slot and issue a busy one, never the same
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            if (do_alloc) valid_q[free_idx] <= 1'b1;
            if (issue_fire) valid_q[issue_idx] <= 1'b0;
        end
    end

endmodule

//--- logic/rs_entry_store.sv
`include "rs_params.svh"

module rs_entry_store (
    input logic clk,
    input logic reset,
    cdb_if.sink cdb,
    rs_alloc_if.store alloc,
    input rs_pkg::rs_idx_t read_idx,
    output rs_pkg::issue_word_t read_word,
    output rs_pkg::rs_vec_t entry_ready
);
    import isa_pkg::*;
    import rs_pkg::*;

    rs_payload_t payload_mem [`RS_DEPTH];
    operand_u src1_mem [`RS_DEPTH];
    operand_u src2_mem [`RS_DEPTH];
    rs_vec_t src1_rdy;
    rs_vec_t src2_rdy;

    rs_vec_t wr_sel;  // entry targeted by dispatch
    rs_vec_t hit1;    // waiting tag seen on a bus
    rs_vec_t hit2;
    word_t wake1_val [`RS_DEPTH];
    word_t wake2_val [`RS_DEPTH];

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            wr_sel[i] = alloc.write && (alloc.idx == rs_idx_t'(i));
            hit1[i] = cdb.lookup(src1_mem[i].waiting.tag, wake1_val[i]);
            hit1[i] = hit1[i] & ~src1_rdy[i]; // only while still waiting
            hit2[i] = cdb.lookup(src2_mem[i].waiting.tag, wake2_val[i]);
            hit2[i] = hit2[i] & ~src2_rdy[i];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            src1_rdy <= '0;
            src2_rdy <= '0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (wr_sel[i]) begin // new entry beats wakeup
                    src1_rdy[i] <= alloc.src1_ready;
                    src2_rdy[i] <= alloc.src2_ready;
                end else begin
                    src1_rdy[i] <= src1_rdy[i] | hit1[i];
                    src2_rdy[i] <= src2_rdy[i] | hit2[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (wr_sel[i]) begin
                payload_mem[i] <= alloc.payload;
                src1_mem[i] <= alloc.src1;
                src2_mem[i] <= alloc.src2;
            end else begin
                if (hit1[i]) src1_mem[i].value <= wake1_val[i];
                if (hit2[i]) src2_mem[i].value <= wake2_val[i];
            end
        end
    end

    assign entry_ready = src1_rdy & src2_rdy;

    always_comb begin
        read_word.payload = payload_mem[read_idx];
        read_word.src1 = src1_mem[read_idx].value;
        read_word.src2 = src2_mem[read_idx].value;
    end

endmodule

//--- logic/rs_issue_mux.sv
module rs_issue_mux (
    input logic clk,
    input logic reset,
    input logic issue_fire,
    input rs_pkg::rs_idx_t issue_idx,
    output rs_pkg::rs_idx_t read_idx,
    input rs_pkg::issue_word_t read_word,
    output logic issue_valid,
    output isa_pkg::pc_t issue_pc,
    output isa_pkg::preg_t issue_rd,
    output isa_pkg::div_op_t issue_op,
    output isa_pkg::word_t issue_src1,
    output isa_pkg::word_t issue_src2
);
    import rs_pkg::*;

    issue_word_t issue_q; // last issued entry

    assign read_idx = issue_idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_fire; // one cycle pulse per entry
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) issue_q <= read_word;
    end

    assign issue_pc = issue_q.payload.pc;
    assign issue_rd = issue_q.payload.rd;
    assign issue_op = issue_q.payload.op;
    assign issue_src1 = issue_q.src1;
    assign issue_src2 = issue_q.src2;

endmodule

//--- logic/rs_operand_capture.sv
module rs_operand_capture (
    input isa_pkg::pc_t dispatch_pc,
    input isa_pkg::preg_t dispatch_rd,
    input isa_pkg::div_op_t dispatch_op,
    input logic src1_ready,
    input rs_pkg::operand_u src1_word,
    input logic src2_ready,
    input rs_pkg::operand_u src2_word,
    cdb_if.sink cdb,
    rs_alloc_if.capture alloc
);
    import isa_pkg::*;
    import rs_pkg::*;

    logic hit1;
    logic hit2;
    word_t bus1; // bus value for src1 tag
    word_t bus2;

    always_comb begin
        hit1 = cdb.lookup(src1_word.waiting.tag, bus1);
        hit2 = cdb.lookup(src2_word.waiting.tag, bus2);
    end

    // a source arriving as a tag may already be on a bus this cycle
    always_comb begin
        alloc.src1 = src1_word;
        alloc.src1_ready = src1_ready;
        if (!src1_ready && hit1) begin
            alloc.src1.value = bus1;
            alloc.src1_ready = 1'b1;
        end

        alloc.src2 = src2_word;
        alloc.src2_ready = src2_ready;
        if (!src2_ready && hit2) begin
            alloc.src2.value = bus2;
            alloc.src2_ready = 1'b1;
        end
    end

    always_comb begin
        alloc.payload.pc = dispatch_pc;
        alloc.payload.rd = dispatch_rd;
        alloc.payload.op = dispatch_op;
    end

endmodule

//--- logic/rs_params.svh
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

`define RS_DEPTH 8 // entries in the station
`define RS_IDX_W 3 // log2 of depth

`define DATA_W 32 // operand value
`define TAG_W 8   // physical register tag
`define PC_W 32
`define OP_W 4    // divide opcode

`endif

//--- logic/rs_pkg.sv
`include "rs_params.svh"

package rs_pkg;

    typedef logic [`RS_IDX_W-1:0] rs_idx_t;
    typedef logic [`RS_DEPTH-1:0] rs_vec_t; // one bit per entry

    // operand slot, holds the value once ready, else the tag it waits on
    typedef union packed {
        isa_pkg::word_t value;
        struct packed {
            logic [`DATA_W-`TAG_W-1:0] pad;
            isa_pkg::preg_t tag;
        } waiting;
    } operand_u;

    typedef struct packed {
        isa_pkg::pc_t pc;
        isa_pkg::preg_t rd;
        isa_pkg::div_op_t op;
    } rs_payload_t;

    typedef struct packed {
        rs_payload_t payload;
        isa_pkg::word_t src1;
        isa_pkg::word_t src2;
    } issue_word_t;

endpackage

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_rs_div -o tb_rs_div

./obj_dir/tb_rs_div | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

//--- src.f
+incdir+logic
logic/isa_pkg.sv
logic/rs_pkg.sv
logic/cdb_if.sv
logic/rs_alloc_if.sv
logic/rs_operand_capture.sv
logic/rs_entry_store.sv
logic/rs_div_ctrl.sv
logic/rs_issue_mux.sv
logic/rs_div.sv
tests/tb_rs_div.sv

//--- tests/tb_rs_div.sv
`include "rs_params.svh"

module tb_rs_div;
    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import rs_pkg::*;

    localparam int CYCLE_LIMIT = 2000; // tests take about 90 cycles
    localparam int EXPECTED_ISSUES = 17;
    localparam int ALU = 0;
    localparam int MUL = 1;
    localparam int DIV = 2;

    logic clk;
    logic reset;
    logic dispatch_valid;
    pc_t dispatch_pc;
    preg_t dispatch_rd;
    div_op_t dispatch_op;
    logic src1_ready;
    word_t src1_word;
    logic src2_ready;
    word_t src2_word;
    logic alu_valid;
    preg_t alu_tag;
    word_t alu_data;
    logic mul_valid;
    preg_t mul_tag;
    word_t mul_data;
    logic div_valid;
    preg_t div_tag;
    word_t div_data;
    logic issue_valid;
    pc_t issue_pc;
    preg_t issue_rd;
    div_op_t issue_op;
    word_t issue_src1;
    word_t issue_src2;
    logic rs_full;

    rs_vec_t m_valid;  // model of the station
    rs_vec_t m_rdy1;
    rs_vec_t m_rdy2;
    issue_word_t m_entry [`RS_DEPTH]; // tag in low bits while waiting
    issue_word_t exp_issue;
    logic exp_valid;
    logic exp_full;

    int seed;
    int errors;
    int stall_errors;
    int checks;
    int issue_count;
    int cycles;
    string test_name;

    rs_div rs_div_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ALU wins over MUL, MUL over DIV, idle buses never match
    function automatic logic find_broadcast(input preg_t tag, output word_t value);
        value = '0;
        if (alu_valid && alu_tag == tag) begin
            value = alu_data;
        end else if (mul_valid && mul_tag == tag) begin
            value = mul_data;
        end else if (div_valid && div_tag == tag) begin
            value = div_data;
        end else begin
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic step_model();
        logic pick_ok;
        logic slot_ok;
        rs_idx_t pick;
        rs_idx_t slot;
        word_t val;
        pick_ok = 1'b0;
        slot_ok = 1'b0;
        pick = '0;
        slot = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin // lowest index ends up chosen
            if (m_valid[i] && m_rdy1[i] && m_rdy2[i]) begin
                pick_ok = 1'b1;
                pick = rs_idx_t'(i);
            end
            if (!m_valid[i]) begin
                slot_ok = 1'b1;
                slot = rs_idx_t'(i);
            end
        end
        exp_valid = pick_ok;
        if (pick_ok) exp_issue = m_entry[pick];
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (!m_rdy1[i] && find_broadcast(m_entry[i].src1[`TAG_W-1:0], val)) begin
                m_entry[i].src1 = val;
                m_rdy1[i] = 1'b1;
            end
            if (!m_rdy2[i] && find_broadcast(m_entry[i].src2[`TAG_W-1:0], val)) begin
                m_entry[i].src2 = val;
                m_rdy2[i] = 1'b1;
            end
        end
        if (pick_ok) m_valid[pick] = 1'b0;
        if (dispatch_valid && slot_ok) begin // no free slot means the dispatch is dropped
            m_valid[slot] = 1'b1;
            m_rdy1[slot] = src1_ready;
            m_rdy2[slot] = src2_ready;
            m_entry[slot] = {dispatch_pc, dispatch_rd, dispatch_op, src1_word, src2_word};
            if (!src1_ready && find_broadcast(src1_word[`TAG_W-1:0], val)) begin
                m_entry[slot].src1 = val;
                m_rdy1[slot] = 1'b1;
            end
            if (!src2_ready && find_broadcast(src2_word[`TAG_W-1:0], val)) begin
                m_entry[slot].src2 = val;
                m_rdy2[slot] = 1'b1;
            end
        end
        exp_full = &m_valid;
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_valid = '0;
            exp_valid = 1'b0;
            exp_full = 1'b0;
        end else begin
            step_model();
        end
    end

    task automatic log_mismatch(input string field, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("FAILED %s %s: expected %h, got %h", test_name, field, expected, actual);
    endtask

    full_tracks: assert property (@(negedge clk) disable iff (reset) rs_full === exp_full)
        else log_mismatch("rs_full", 32'(exp_full), 32'(rs_full));

    always @(negedge clk) begin
        if (!reset) begin
            checks++;
            if (issue_valid) issue_count++;
            valid_tracks: assert (issue_valid === exp_valid) else begin
                errors++;
                if (exp_valid) $display("missing issue in test %s", test_name);
                else $display("unexpected issue in test %s, pc %h", test_name, issue_pc);
            end
            if (exp_valid && issue_valid) begin
                assert (issue_pc === exp_issue.payload.pc)
                    else log_mismatch("issue_pc", exp_issue.payload.pc, issue_pc);
                assert (issue_rd === exp_issue.payload.rd)
                    else log_mismatch("issue_rd", 32'(exp_issue.payload.rd), 32'(issue_rd));
                assert (issue_op === exp_issue.payload.op)
                    else log_mismatch("issue_op", 32'(exp_issue.payload.op), 32'(issue_op));
                assert (issue_src1 === exp_issue.src1)
                    else log_mismatch("issue_src1", exp_issue.src1, issue_src1);
                assert (issue_src2 === exp_issue.src2)
                    else log_mismatch("issue_src2", exp_issue.src2, issue_src2);
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #10;
        dispatch_valid = 1'b0; // strobes last one cycle
        alu_valid = 1'b0;
        mul_valid = 1'b0;
        div_valid = 1'b0;
    endtask

    task automatic drive_dispatch(input preg_t rd, input logic r1, input word_t w1,
                                  input logic r2, input word_t w2);
        dispatch_valid = 1'b1;
        dispatch_pc = $random(seed);
        dispatch_rd = rd;
        dispatch_op = 4'($random(seed));
        src1_ready = r1;
        src1_word = w1;
        src2_ready = r2;
        src2_word = w2;
    endtask

    task automatic broadcast(input int unit, input preg_t tag, input word_t data);
        case (unit)
            ALU: begin
                alu_valid = 1'b1;
                alu_tag = tag;
                alu_data = data;
            end
            MUL: begin
                mul_valid = 1'b1;
                mul_tag = tag;
                mul_data = data;
            end
            default: begin
                div_valid = 1'b1;
                div_tag = tag;
                div_data = data;
            end
        endcase
    endtask

    function automatic word_t as_waiting(input preg_t tag);
        return word_t'(tag);
    endfunction

    task automatic wait_issues(input int target);
        int waited;
        waited = 0;
        while (issue_count < target && waited < 20) begin
            tick();
            waited++;
        end
        issue_arrived: assert (issue_count >= target) else begin
            stall_errors++;
            $display("issue never came in test %s, saw %0d of %0d", test_name,
                     issue_count, target);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run hit the %0d cycle limit in test %s", CYCLE_LIMIT, test_name);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int total;
        seed = 40595;
        errors = 0;
        stall_errors = 0;
        checks = 0;
        issue_count = 0;
        test_name = "reset";
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_pc = '0;
        dispatch_rd = '0;
        dispatch_op = '0;
        src1_ready = 1'b0;
        src1_word = '0;
        src2_ready = 1'b0;
        src2_word = '0;
        alu_valid = 1'b0;
        alu_tag = '0;
        alu_data = '0;
        mul_valid = 1'b0;
        mul_tag = '0;
        mul_data = '0;
        div_valid = 1'b0;
        div_tag = '0;
        div_data = '0;
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
        tick();
        tick();

        test_name = "ready_issue";
        drive_dispatch(8'h11, 1'b1, $random(seed), 1'b1, $random(seed));
        tick();
        wait_issues(1);

        test_name = "wakeup";
        drive_dispatch(8'h12, 1'b0, as_waiting(8'h21), 1'b1, $random(seed));
        repeat (4) tick(); // tag still unbroadcast
        broadcast(MUL, 8'h21, $random(seed));
        tick();
        wait_issues(2);

        test_name = "capture_priority";
        drive_dispatch(8'h13, 1'b1, $random(seed), 1'b0, as_waiting(8'h31));
        broadcast(ALU, 8'h31, $random(seed));
        broadcast(DIV, 8'h31, $random(seed));
        tick();
        wait_issues(3);

        test_name = "capture_idle_bus";
        drive_dispatch(8'h14, 1'b0, as_waiting(8'h32), 1'b1, $random(seed));
        alu_tag = 8'h32; // tag matches while valid stays low
        alu_data = $random(seed);
        repeat (3) tick();
        broadcast(DIV, 8'h32, $random(seed));
        tick();
        wait_issues(4);

        test_name = "issue_order";
        for (int i = 0; i < 4; i++) begin
            drive_dispatch(8'h40 + 8'(i), 1'b0, as_waiting(8'h41), 1'b1, $random(seed));
            tick();
        end
        broadcast(ALU, 8'h41, $random(seed));
        tick();
        wait_issues(8);

        test_name = "full";
        for (int i = 0; i < 8; i++) begin
            drive_dispatch(8'h50 + 8'(i), 1'b0, as_waiting(8'h50 + 8'(i)), 1'b1, $random(seed));
            tick();
        end
        drive_dispatch(8'h5f, 1'b1, $random(seed), 1'b1, $random(seed)); // dropped
        repeat (3) tick();
        broadcast(ALU, 8'h50, $random(seed));
        tick();
        wait_issues(9);

        test_name = "refill";
        drive_dispatch(8'h60, 1'b0, as_waiting(8'h60), 1'b1, $random(seed));
        tick();
        broadcast(ALU, 8'h51, $random(seed));
        broadcast(MUL, 8'h60, $random(seed)); // refill in slot 0 goes before slot 1
        tick();
        broadcast(ALU, 8'h52, $random(seed));
        broadcast(MUL, 8'h53, $random(seed));
        broadcast(DIV, 8'h54, $random(seed));
        tick();
        broadcast(ALU, 8'h55, $random(seed));
        broadcast(MUL, 8'h56, $random(seed));
        broadcast(DIV, 8'h57, $random(seed));
        tick();
        wait_issues(EXPECTED_ISSUES);
        repeat (4) tick();

        test_name = "closing";
        total = errors + stall_errors;
        issue_total: assert (issue_count == EXPECTED_ISSUES) else begin
            total++;
            $display("FAILED %s issue count: expected %0d, got %0d", test_name,
                     EXPECTED_ISSUES, issue_count);
        end
        $display("checks %0d, issues %0d, errors %0d", checks, issue_count, total);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
